// File: include/hybrid_mem_config.svh
/*
  Build-time sizing of the hybrid SPM/cache memory.
  HM_NUM_BANKS and HM_NUM_WORDS must be powers of two.
  HM_RESP_LATENCY must be at least 1.
*/
`ifndef HYBRID_MEM_CONFIG_SVH
`define HYBRID_MEM_CONFIG_SVH

// Number of banks with one cache port each
`define HM_NUM_BANKS 4

// Total words across all banks
`define HM_NUM_WORDS 256

`define HM_DATA_WIDTH 32
`define HM_BYTE_WIDTH 8

// Cycles from the accepting edge to read data at the ports
`define HM_RESP_LATENCY 1

`define HM_BANK_WORDS (`HM_NUM_WORDS / `HM_NUM_BANKS)

`endif

// File: hdl/hybrid_mem_pkg.sv
/*
  Shared vector types of the hybrid memory.
  All widths derive from the config header.
*/
`include "hybrid_mem_config.svh"

package hybrid_mem_pkg;

  // Address split of a flat SPM word address
  localparam int unsigned BANK_SEL_W  = $clog2(`HM_NUM_BANKS);
  localparam int unsigned MEM_ADDR_W  = $clog2(`HM_NUM_WORDS);
  localparam int unsigned BANK_ADDR_W = MEM_ADDR_W - BANK_SEL_W;

  // Byte lanes per word
  localparam int unsigned NUM_BYTES = `HM_DATA_WIDTH / `HM_BYTE_WIDTH;

  // One data word
  typedef logic [`HM_DATA_WIDTH-1:0] data_t;

  // One enable bit per byte lane
  typedef logic [NUM_BYTES-1:0] be_t;

  // Flat SPM word address with the bank index in the low bits
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // Word address inside a single bank
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

  // Bank index
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;

endpackage

// File: hdl/sram_bank.sv
/*
  Single-port SRAM bank with byte-masked writes.
  Read data appears HM_RESP_LATENCY cycles after the request edge.
  Contents start at zero in simulation and are never reset.
*/
`timescale 1ns/1ns
`include "hybrid_mem_config.svh"

module sram_bank (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  hybrid_mem_pkg::bank_addr_t addr_i,
  input  hybrid_mem_pkg::data_t  wdata_i,
  input  hybrid_mem_pkg::be_t    be_i,
  output hybrid_mem_pkg::data_t  rdata_o
);
  import hybrid_mem_pkg::*;

  data_t mem_q [`HM_BANK_WORDS];

  // Stage 0 holds the word read at the request edge
  data_t rd_pipe_q [`HM_RESP_LATENCY];

  initial begin
    for (int w = 0; w < `HM_BANK_WORDS; w++) begin
      mem_q[w] = '0;
    end
  end

  // Only enabled byte lanes change on a write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*`HM_BYTE_WIDTH +: `HM_BYTE_WIDTH] <=
            wdata_i[b*`HM_BYTE_WIDTH +: `HM_BYTE_WIDTH];
        end
      end
    end
  end

  // Read port plus the extra output stages
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rd_pipe_q[0] <= mem_q[addr_i];
    end
    for (int s = 1; s < `HM_RESP_LATENCY; s++) begin
      rd_pipe_q[s] <= rd_pipe_q[s-1];
    end
  end

  assign rdata_o = rd_pipe_q[`HM_RESP_LATENCY-1];

  // An unknown address would corrupt an arbitrary word
  addr_known_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_i |-> !$isunknown({we_i, addr_i})
  ) else $error("sram_bank: request with unknown address or write enable");

endmodule

// File: hdl/bank_port_arbiter.sv
/*
  Per-bank choice between the SPM and the cache request, purely combinational.
  SPM always wins; the cache port is stalled on a conflict.
  Cache requests below spm_size_i never reach the bank.
*/
`timescale 1ns/1ns

module bank_port_arbiter (
  input  logic                       spm_valid_i,
  input  logic                       spm_we_i,
  input  hybrid_mem_pkg::bank_addr_t spm_addr_i,
  input  hybrid_mem_pkg::data_t      spm_wdata_i,
  input  hybrid_mem_pkg::be_t        spm_be_i,
  input  logic                       cache_req_i,
  input  logic                       cache_we_i,
  input  hybrid_mem_pkg::bank_addr_t cache_addr_i,
  input  hybrid_mem_pkg::data_t      cache_wdata_i,
  input  hybrid_mem_pkg::be_t        cache_be_i,
  input  hybrid_mem_pkg::bank_addr_t spm_size_i,
  output logic                       cache_ready_o,
  output logic                       bank_req_o,
  output logic                       bank_we_o,
  output hybrid_mem_pkg::bank_addr_t bank_addr_o,
  output hybrid_mem_pkg::data_t      bank_wdata_o,
  output hybrid_mem_pkg::be_t        bank_be_o,
  output logic                       owner_spm_o,
  output logic                       cache_read_o,
  output logic                       cache_err_o
);

  logic cache_illegal;
  logic cache_go;

  // SPM has a fixed-latency contract, so the cache side waits
  assign cache_ready_o = !spm_valid_i;

  // Lower region belongs to the SPM
  assign cache_illegal = cache_req_i && (cache_addr_i < spm_size_i);

  // Legal cache request accepted this cycle
  assign cache_go = cache_req_i && cache_ready_o && !cache_illegal;

  assign owner_spm_o  = spm_valid_i;
  assign bank_req_o   = spm_valid_i || cache_go;
  assign bank_we_o    = spm_valid_i ? spm_we_i    : cache_we_i;
  assign bank_addr_o  = spm_valid_i ? spm_addr_i  : cache_addr_i;
  assign bank_wdata_o = spm_valid_i ? spm_wdata_i : cache_wdata_i;
  assign bank_be_o    = spm_valid_i ? spm_be_i    : cache_be_i;

  assign cache_read_o = cache_go && !cache_we_i;

  // Illegal requests still complete with an error response
  assign cache_err_o = cache_illegal && cache_ready_o;

endmodule

// File: hdl/resp_route_pipe.sv
/*
  Delays ownership and error flags by HM_RESP_LATENCY cycles and steers
  each bank's read data to the SPM port or to that bank's cache port.
  Idle and error responses carry zero data.
*/
`timescale 1ns/1ns
`include "hybrid_mem_config.svh"

module resp_route_pipe (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     spm_read_i,
  input  hybrid_mem_pkg::bank_sel_t                spm_sel_i,
  input  logic [`HM_NUM_BANKS-1:0]                 cache_read_i,
  input  logic [`HM_NUM_BANKS-1:0]                 cache_err_i,
  input  hybrid_mem_pkg::data_t [`HM_NUM_BANKS-1:0] bank_rdata_i,
  output hybrid_mem_pkg::data_t                    spm_rdata_o,
  output logic                                     spm_rvalid_o,
  output hybrid_mem_pkg::data_t [`HM_NUM_BANKS-1:0] cache_rdata_o,
  output logic [`HM_NUM_BANKS-1:0]                 cache_rvalid_o,
  output logic [`HM_NUM_BANKS-1:0]                 cache_err_o
);
  import hybrid_mem_pkg::*;

  localparam int unsigned LAST = `HM_RESP_LATENCY - 1;

  logic                     spm_vld_q   [`HM_RESP_LATENCY];
  bank_sel_t                spm_sel_q   [`HM_RESP_LATENCY];
  logic [`HM_NUM_BANKS-1:0] cache_rd_q  [`HM_RESP_LATENCY];
  logic [`HM_NUM_BANKS-1:0] cache_err_q [`HM_RESP_LATENCY];

  // Response flags with one entry per cycle in flight
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `HM_RESP_LATENCY; s++) begin
        spm_vld_q[s]   <= 1'b0;
        cache_rd_q[s]  <= '0;
        cache_err_q[s] <= '0;
      end
    end else begin
      spm_vld_q[0]   <= spm_read_i;
      cache_rd_q[0]  <= cache_read_i;
      cache_err_q[0] <= cache_err_i;
      for (int s = 1; s < `HM_RESP_LATENCY; s++) begin
        spm_vld_q[s]   <= spm_vld_q[s-1];
        cache_rd_q[s]  <= cache_rd_q[s-1];
        cache_err_q[s] <= cache_err_q[s-1];
      end
    end
  end

  // Bank select travels next to the SPM valid flag
  always_ff @(posedge clk_i) begin
    spm_sel_q[0] <= spm_sel_i;
    for (int s = 1; s < `HM_RESP_LATENCY; s++) begin
      spm_sel_q[s] <= spm_sel_q[s-1];
    end
  end

  always_comb begin
    spm_rvalid_o = spm_vld_q[LAST];
    spm_rdata_o  = '0;
    if (spm_vld_q[LAST]) begin
      spm_rdata_o = bank_rdata_i[spm_sel_q[LAST]];
    end
    for (int i = 0; i < `HM_NUM_BANKS; i++) begin
      cache_err_o[i]    = cache_err_q[LAST][i];
      cache_rvalid_o[i] = cache_rd_q[LAST][i] || cache_err_q[LAST][i];
      cache_rdata_o[i]  = cache_rd_q[LAST][i] ? bank_rdata_i[i] : '0;
    end
  end

  // Arbitration upstream must keep bank ownership exclusive
  single_owner_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    spm_vld_q[LAST] |-> !cache_rd_q[LAST][spm_sel_q[LAST]]
  ) else $error("resp_route_pipe: SPM and cache both claim one bank's data");

endmodule

// File: hdl/hybrid_mem.sv
/*
  Banked memory shared by one SPM port and one cache port per bank.
  Low SPM address bits select the bank; the SPM never stalls.
  All responses arrive HM_RESP_LATENCY cycles after acceptance.
*/
`timescale 1ns/1ns
`include "hybrid_mem_config.svh"

module hybrid_mem (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  // Run-time SPM/cache boundary inside every bank
  input  hybrid_mem_pkg::bank_addr_t                    spm_size_i,
  // SPM port
  input  logic                                          spm_req_i,
  input  logic                                          spm_we_i,
  input  hybrid_mem_pkg::mem_addr_t                     spm_addr_i,
  input  hybrid_mem_pkg::data_t                         spm_wdata_i,
  input  hybrid_mem_pkg::be_t                           spm_be_i,
  output hybrid_mem_pkg::data_t                         spm_rdata_o,
  output logic                                          spm_rvalid_o,
  // One cache port per bank
  input  logic [`HM_NUM_BANKS-1:0]                      cache_req_i,
  input  logic [`HM_NUM_BANKS-1:0]                      cache_we_i,
  input  hybrid_mem_pkg::bank_addr_t [`HM_NUM_BANKS-1:0] cache_addr_i,
  input  hybrid_mem_pkg::data_t [`HM_NUM_BANKS-1:0]      cache_wdata_i,
  input  hybrid_mem_pkg::be_t [`HM_NUM_BANKS-1:0]        cache_be_i,
  output logic [`HM_NUM_BANKS-1:0]                      cache_ready_o,
  output hybrid_mem_pkg::data_t [`HM_NUM_BANKS-1:0]      cache_rdata_o,
  output logic [`HM_NUM_BANKS-1:0]                      cache_rvalid_o,
  output logic [`HM_NUM_BANKS-1:0]                      cache_err_o
);
  import hybrid_mem_pkg::*;

  bank_sel_t                     spm_sel;
  bank_addr_t                    spm_bank_addr;
  logic                          spm_read;
  logic [`HM_NUM_BANKS-1:0]      spm_valid;

  logic [`HM_NUM_BANKS-1:0]      bank_req;
  logic [`HM_NUM_BANKS-1:0]      bank_we;
  bank_addr_t [`HM_NUM_BANKS-1:0] bank_addr;
  data_t [`HM_NUM_BANKS-1:0]      bank_wdata;
  be_t [`HM_NUM_BANKS-1:0]        bank_be;
  data_t [`HM_NUM_BANKS-1:0]      bank_rdata;

  logic [`HM_NUM_BANKS-1:0]      cache_read;
  logic [`HM_NUM_BANKS-1:0]      cache_err;

  // Word-interleaved banks
  assign spm_sel       = spm_addr_i[BANK_SEL_W-1:0];
  assign spm_bank_addr = spm_addr_i[MEM_ADDR_W-1:BANK_SEL_W];

  always_comb begin
    spm_valid          = '0;
    spm_valid[spm_sel] = spm_req_i;
  end

  // Writes produce no response
  assign spm_read = spm_req_i && !spm_we_i;

  for (genvar i = 0; i < `HM_NUM_BANKS; i++) begin : gen_banks
    bank_port_arbiter u_arb (
      .spm_valid_i   (spm_valid[i]),
      .spm_we_i      (spm_we_i),
      .spm_addr_i    (spm_bank_addr),
      .spm_wdata_i   (spm_wdata_i),
      .spm_be_i      (spm_be_i),
      .cache_req_i   (cache_req_i[i]),
      .cache_we_i    (cache_we_i[i]),
      .cache_addr_i  (cache_addr_i[i]),
      .cache_wdata_i (cache_wdata_i[i]),
      .cache_be_i    (cache_be_i[i]),
      .spm_size_i    (spm_size_i),
      .cache_ready_o (cache_ready_o[i]),
      .bank_req_o    (bank_req[i]),
      .bank_we_o     (bank_we[i]),
      .bank_addr_o   (bank_addr[i]),
      .bank_wdata_o  (bank_wdata[i]),
      .bank_be_o     (bank_be[i]),
      .owner_spm_o   (),
      .cache_read_o  (cache_read[i]),
      .cache_err_o   (cache_err[i])
    );

    sram_bank u_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (bank_req[i]),
      .we_i    (bank_we[i]),
      .addr_i  (bank_addr[i]),
      .wdata_i (bank_wdata[i]),
      .be_i    (bank_be[i]),
      .rdata_o (bank_rdata[i])
    );
  end

  resp_route_pipe u_pipe (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .spm_read_i     (spm_read),
    .spm_sel_i      (spm_sel),
    .cache_read_i   (cache_read),
    .cache_err_i    (cache_err),
    .bank_rdata_i   (bank_rdata),
    .spm_rdata_o    (spm_rdata_o),
    .spm_rvalid_o   (spm_rvalid_o),
    .cache_rdata_o  (cache_rdata_o),
    .cache_rvalid_o (cache_rvalid_o),
    .cache_err_o    (cache_err_o)
  );

endmodule

// File: sim/hybrid_mem_tb.sv
/*
  Random testbench for hybrid_mem with a word-level reference model.
  Expected responses are queued per port and must show up exactly
  HM_RESP_LATENCY cycles after the accepting edge.
*/
`timescale 1ns/1ns
`include "hybrid_mem_config.svh"

module hybrid_mem_tb;
  import hybrid_mem_pkg::*;

  localparam int NB  = `HM_NUM_BANKS;
  localparam int LAT = `HM_RESP_LATENCY;

  // Cycle budget of each phase
  localparam int RESET_CYC    = 2;
  localparam int IDLE_CYC     = 4;
  localparam int ZERO_CYC     = 16;
  localparam int SPM_CYC      = 64;
  localparam int CACHE_CYC    = 200;
  localparam int CROSS_ROUNDS = 8;
  localparam int CROSS_CYC    = CROSS_ROUNDS * (2 + 2 * NB);
  localparam int CONFLICT_CYC = 200;
  localparam int ILLEGAL_CYC  = 200;
  localparam int MIXED_CYC    = 1000;
  localparam int DRAIN_CYC    = LAT + 8;
  localparam int TEST_CYCLES  = RESET_CYC + IDLE_CYC + ZERO_CYC + 2 * SPM_CYC + CACHE_CYC +
                                CROSS_CYC + CONFLICT_CYC + ILLEGAL_CYC + MIXED_CYC + DRAIN_CYC;

  logic                 clk_i;
  logic                 reset_i;
  bank_addr_t           spm_size_i;
  logic                 spm_req_i;
  logic                 spm_we_i;
  mem_addr_t            spm_addr_i;
  data_t                spm_wdata_i;
  be_t                  spm_be_i;
  data_t                spm_rdata_o;
  logic                 spm_rvalid_o;
  logic [NB-1:0]        cache_req_i;
  logic [NB-1:0]        cache_we_i;
  bank_addr_t [NB-1:0]  cache_addr_i;
  data_t [NB-1:0]       cache_wdata_i;
  be_t [NB-1:0]         cache_be_i;
  logic [NB-1:0]        cache_ready_o;
  data_t [NB-1:0]       cache_rdata_o;
  logic [NB-1:0]        cache_rvalid_o;
  logic [NB-1:0]        cache_err_o;

  // Reference model and expected responses
  data_t         model_mem [`HM_NUM_WORDS];
  data_t         spm_exp_data [$];
  int            spm_exp_due [$];
  data_t         cache_exp_data [NB][$];
  logic          cache_exp_err [NB][$];
  int            cache_exp_due [NB][$];
  logic [NB-1:0] cache_acc;
  integer        seed;
  int            cyc;
  int            stall_seen;
  int            err_seen;
  mem_addr_t     spm_mask;
  bank_addr_t    cache_mask;

  hybrid_mem u_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .spm_size_i     (spm_size_i),
    .spm_req_i      (spm_req_i),
    .spm_we_i       (spm_we_i),
    .spm_addr_i     (spm_addr_i),
    .spm_wdata_i    (spm_wdata_i),
    .spm_be_i       (spm_be_i),
    .spm_rdata_o    (spm_rdata_o),
    .spm_rvalid_o   (spm_rvalid_o),
    .cache_req_i    (cache_req_i),
    .cache_we_i     (cache_we_i),
    .cache_addr_i   (cache_addr_i),
    .cache_wdata_i  (cache_wdata_i),
    .cache_be_i     (cache_be_i),
    .cache_ready_o  (cache_ready_o),
    .cache_rdata_o  (cache_rdata_o),
    .cache_rvalid_o (cache_rvalid_o),
    .cache_err_o    (cache_err_o)
  );

  always #2 clk_i = ~clk_i;

  task abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task compare(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic int unsigned pick(input int unsigned n);
    pick = $unsigned($random(seed)) % n;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
    data_t res;
    res = old;
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (be[b]) begin
        res[b*`HM_BYTE_WIDTH +: `HM_BYTE_WIDTH] = wdata[b*`HM_BYTE_WIDTH +: `HM_BYTE_WIDTH];
      end
    end
    return res;
  endfunction

  function automatic int pending_responses();
    int n;
    n = spm_exp_due.size();
    for (int i = 0; i < NB; i++) begin
      n += cache_exp_due[i].size();
    end
    return n;
  endfunction

  // A response is due when the oldest entry of its queue matches this cycle
  task check_responses();
    logic  exp_v;
    logic  exp_e;
    data_t exp_d;
    exp_v = (spm_exp_due.size() > 0) && (spm_exp_due[0] == cyc);
    exp_d = '0;
    if (exp_v) begin
      exp_d = spm_exp_data.pop_front();
      void'(spm_exp_due.pop_front());
    end
    compare("spm_rvalid_o", spm_rvalid_o, exp_v);
    compare("spm_rdata_o", spm_rdata_o, exp_d);
    for (int i = 0; i < NB; i++) begin
      exp_v = (cache_exp_due[i].size() > 0) && (cache_exp_due[i][0] == cyc);
      exp_e = 1'b0;
      exp_d = '0;
      if (exp_v) begin
        exp_d = cache_exp_data[i].pop_front();
        exp_e = cache_exp_err[i].pop_front();
        void'(cache_exp_due[i].pop_front());
      end
      compare($sformatf("cache_rvalid_o[%0d]", i), cache_rvalid_o[i], exp_v);
      compare($sformatf("cache_err_o[%0d]", i), cache_err_o[i], exp_e);
      compare($sformatf("cache_rdata_o[%0d]", i), cache_rdata_o[i], exp_d);
    end
  endtask

  // Acceptance and model update for the requests sampled at this edge
  task apply_requests();
    int   flat;
    logic spm_hit;
    if (spm_req_i) begin
      flat = spm_addr_i;
      if (spm_we_i) begin
        model_mem[flat] = merge_bytes(model_mem[flat], spm_wdata_i, spm_be_i);
      end else begin
        spm_exp_data.push_back(model_mem[flat]);
        spm_exp_due.push_back(cyc + LAT);
      end
    end
    for (int i = 0; i < NB; i++) begin
      spm_hit = spm_req_i && ((int'(spm_addr_i) % NB) == i);
      compare($sformatf("cache_ready_o[%0d]", i), cache_ready_o[i], !spm_hit);
      cache_acc[i] = cache_req_i[i] && !spm_hit;
      if (cache_req_i[i] && spm_hit) begin
        stall_seen++;
      end
      if (cache_acc[i]) begin
        flat = int'(cache_addr_i[i]) * NB + i;
        if (cache_addr_i[i] < spm_size_i) begin
          // Illegal region gives an error entry with zero data
          cache_exp_data[i].push_back('0);
          cache_exp_err[i].push_back(1'b1);
          cache_exp_due[i].push_back(cyc + LAT);
          err_seen++;
        end else if (cache_we_i[i]) begin
          model_mem[flat] = merge_bytes(model_mem[flat], cache_wdata_i[i], cache_be_i[i]);
        end else begin
          cache_exp_data[i].push_back(model_mem[flat]);
          cache_exp_err[i].push_back(1'b0);
          cache_exp_due[i].push_back(cyc + LAT);
        end
      end
    end
  endtask

  task tick();
    @(posedge clk_i);
    cyc++;
    if (!reset_i) begin
      check_responses();
      apply_requests();
    end
  endtask

  task drive_next(input int spm_pct, input int spm_wr_pct, input int cache_pct,
                  input int cache_wr_pct);
    spm_req_i   <= pick(100) < spm_pct;
    spm_we_i    <= pick(100) < spm_wr_pct;
    spm_addr_i  <= mem_addr_t'($random(seed)) & spm_mask;
    spm_wdata_i <= $random(seed);
    spm_be_i    <= be_t'(pick(1 << NUM_BYTES));
    for (int i = 0; i < NB; i++) begin
      // A stalled request is held unchanged
      if (!(cache_req_i[i] && !cache_acc[i])) begin
        cache_req_i[i]   <= pick(100) < cache_pct;
        cache_we_i[i]    <= pick(100) < cache_wr_pct;
        cache_addr_i[i]  <= bank_addr_t'($random(seed)) & cache_mask;
        cache_wdata_i[i] <= $random(seed);
        cache_be_i[i]    <= be_t'(pick(1 << NUM_BYTES));
      end
    end
  endtask

  task run_phase(input int n, input int spm_pct, input int spm_wr_pct, input int cache_pct,
                 input int cache_wr_pct);
    repeat (n) begin
      drive_next(spm_pct, spm_wr_pct, cache_pct, cache_wr_pct);
      tick();
    end
  endtask

  // Cache writes read back through SPM, then SPM writes read back by the cache
  task cross_round();
    bank_addr_t a [NB];
    bank_addr_t b [NB];
    for (int i = 0; i < NB; i++) begin
      a[i] = bank_addr_t'($random(seed));
      b[i] = bank_addr_t'($random(seed));
    end
    spm_req_i <= 1'b0;
    for (int i = 0; i < NB; i++) begin
      cache_req_i[i]   <= 1'b1;
      cache_we_i[i]    <= 1'b1;
      cache_addr_i[i]  <= a[i];
      cache_wdata_i[i] <= $random(seed);
      cache_be_i[i]    <= '1;
    end
    tick();
    cache_req_i <= '0;
    for (int i = 0; i < NB; i++) begin
      spm_req_i  <= 1'b1;
      spm_we_i   <= 1'b0;
      spm_addr_i <= mem_addr_t'(int'(a[i]) * NB + i);
      tick();
    end
    for (int i = 0; i < NB; i++) begin
      spm_we_i    <= 1'b1;
      spm_addr_i  <= mem_addr_t'(int'(b[i]) * NB + i);
      spm_wdata_i <= $random(seed);
      spm_be_i    <= be_t'(pick(1 << NUM_BYTES));
      tick();
    end
    spm_req_i <= 1'b0;
    for (int i = 0; i < NB; i++) begin
      cache_req_i[i]  <= 1'b1;
      cache_we_i[i]   <= 1'b0;
      cache_addr_i[i] <= b[i];
    end
    tick();
    cache_req_i <= '0;
  endtask

  initial begin
    seed       = 32'hcdd0;
    cyc        = 0;
    stall_seen = 0;
    err_seen   = 0;
    cache_acc  = '0;
    spm_mask   = '1;
    cache_mask = '1;
    for (int w = 0; w < `HM_NUM_WORDS; w++) begin
      model_mem[w] = '0;
    end
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    spm_size_i    = '0;
    spm_req_i     = 1'b0;
    spm_we_i      = 1'b0;
    spm_addr_i    = '0;
    spm_wdata_i   = '0;
    spm_be_i      = '0;
    cache_req_i   = '0;
    cache_we_i    = '0;
    cache_addr_i  = '0;
    cache_wdata_i = '0;
    cache_be_i    = '0;
    repeat (RESET_CYC) tick();
    reset_i <= 1'b0;

    // Quiet ports after reset, then reads of words nobody wrote
    run_phase(IDLE_CYC, 0, 0, 0, 0);
    run_phase(ZERO_CYC, 100, 0, 0, 0);

    // SPM writes into a small window, then reads of it
    spm_mask = 8'h1f;
    run_phase(SPM_CYC, 100, 100, 0, 0);
    run_phase(SPM_CYC, 100, 0, 0, 0);

    // Cache ports alone with the whole bank legal
    spm_mask = '1;
    spm_size_i <= '0;
    run_phase(CACHE_CYC, 0, 0, 80, 50);
    repeat (CROSS_ROUNDS) cross_round();

    // Narrow windows keep SPM and cache colliding on the same words
    spm_mask   = 8'h0f;
    cache_mask = 6'h03;
    run_phase(CONFLICT_CYC, 60, 40, 80, 40);

    // Moving SPM boundary with many illegal cache accesses
    spm_mask   = '1;
    cache_mask = '1;
    repeat (4) begin
      spm_size_i <= bank_addr_t'(pick(64));
      run_phase(ILLEGAL_CYC / 4, 30, 30, 70, 50);
    end

    // Long mixed run with mostly legal cache accesses
    repeat (4) begin
      spm_size_i <= bank_addr_t'(pick(16));
      run_phase(MIXED_CYC / 4, 50, 40, 70, 40);
    end
    run_phase(DRAIN_CYC, 0, 0, 0, 0);

    if (pending_responses() != 0) begin
      abort_run("Responses were still outstanding at the end of the test");
    end else if (stall_seen == 0 || err_seen == 0) begin
      abort_run("The test never produced an SPM conflict or an illegal cache access");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  initial begin
    #(TEST_CYCLES * 4 + 200);
    abort_run("Watchdog timeout: the test did not finish in time");
  end

endmodule

// File: hybrid_mem.f
+incdir+include
hdl/hybrid_mem_pkg.sv
hdl/sram_bank.sv
hdl/bank_port_arbiter.sv
hdl/resp_route_pipe.sv
hdl/hybrid_mem.sv
sim/hybrid_mem_tb.sv
